/* filelist.f */
logic/bypassPkg.sv
logic/regFile.sv
logic/bypassSpec.sv
logic/bypassData.sv
logic/bypassTop.sv
tb/bypassTop_assertions.sv
tb/bypassTb.sv

/* logic/bypassData.sv */
// Bypass data lane with operand registers, result chains, load data, muxes, write-back select
`timescale 1ns/10ps
`default_nettype none

module bypassData import bypassPkg::*; (
    input  wire logic       phi1,
    input  wire logic       arstN,
    // Selects from the specifier
    input  wire bypassSel_t sSel,
    input  wire bypassSel_t tSel,
    input  wire logic       sLoad,
    input  wire logic       tLoad,
    input  wire logic       wasLoad,
    // Register file read data in R
    input  wire word_t      readS,
    input  wire word_t      readT,
    // Own slot arrives on bResult
    input  wire word_t      aResult,
    input  wire word_t      bResult,
    input  wire word_t      memData,
    output word_t           sBus,
    output word_t           tBus,
    output word_t           wbData
);

    word_t sDataE, tDataE;
    word_t aDataM, bDataM;
    word_t aDataW, bDataW;
    word_t loadDataW;

    // --------------------
    // Pipeline registers
    // --------------------
    always_ff @(posedge phi1 or negedge arstN) begin
        if (!arstN) begin
            sDataE    <= '0;
            tDataE    <= '0;
            aDataM    <= '0;
            bDataM    <= '0;
            aDataW    <= '0;
            bDataW    <= '0;
            loadDataW <= '0;
        end else begin
            // Read data held for E
            sDataE    <= readS;
            tDataE    <= readT;
            // Results sampled at the end of E
            aDataM    <= aResult;
            bDataM    <= bResult;
            aDataW    <= aDataM;
            bDataW    <= bDataM;
            // Load data sampled at the end of M, every cycle
            loadDataW <= memData;
        end
    end

    // --------------------
    // Bypass muxes
    // --------------------
    // AND-OR form relies on a one-hot select
    function automatic word_t pickWord(input bypassSel_t sel, input word_t regData);
        return ({dataW{sel[selAMemBit]}} & aDataM)
             | ({dataW{sel[selBMemBit]}} & bDataM)
             | ({dataW{sel[selAWbBit]}}  & aDataW)
             | ({dataW{sel[selBWbBit]}}  & bDataW)
             | ({dataW{sel[selNoneBit]}} & regData);
    endfunction

    always_comb begin
        // Load data is late so it overrides after the five-way mux
        sBus   = sLoad ? loadDataW : pickWord(sSel, sDataE);
        tBus   = tLoad ? loadDataW : pickWord(tSel, tDataE);
        // Write back load data or the own slot result
        wbData = wasLoad ? loadDataW : bDataW;
    end

endmodule

`default_nettype wire

/* logic/bypassPkg.sv */
// Bypass network package with widths, word and register index types, select encoding
`default_nettype none

package bypassPkg;

    // Datapath and register file sizes
    localparam int dataW    = 32;
    localparam int regIdxW  = 5;
    localparam int numRegs  = 32;

    // Issue slots, slot 0 is A and slot 1 is B
    localparam int numSlots = 2;

    typedef logic [dataW-1:0]   word_t;
    typedef logic [regIdxW-1:0] regIdx_t;

    // --------------------
    // Operand select encoding
    // --------------------
    typedef logic [4:0] bypassSel_t;

    // Result an instruction now in M produced in E
    localparam int selAMemBit = 0;
    localparam int selBMemBit = 1;
    // Result of an instruction now in W
    localparam int selAWbBit  = 2;
    localparam int selBWbBit  = 3;
    // Plain register file data
    localparam int selNoneBit = 4;

    localparam bypassSel_t selNone = bypassSel_t'(1 << selNoneBit);

    // Swap the A and B sources of a select
    // A lane always sees its own slot in the B position
    function automatic bypassSel_t mirrorSel(input bypassSel_t sel);
        bypassSel_t res;
        res = sel;
        res[selAMemBit] = sel[selBMemBit];
        res[selBMemBit] = sel[selAMemBit];
        res[selAWbBit]  = sel[selBWbBit];
        res[selBWbBit]  = sel[selAWbBit];
        return res;
    endfunction

endpackage

`default_nettype wire

/* logic/bypassSpec.sv */
// Bypass specifier with destination pipeline, hazard compare, selects, interlock, write-back
`timescale 1ns/10ps
`default_nettype none

module bypassSpec import bypassPkg::*; (
    input  wire logic    phi1,
    input  wire logic    arstN,
    // Issue in R
    input  wire logic    aValid,
    input  wire logic    bValid,
    input  wire regIdx_t aSrcS,
    input  wire regIdx_t aSrcT,
    input  wire regIdx_t aDest,
    input  wire regIdx_t bSrcS,
    input  wire regIdx_t bSrcT,
    input  wire regIdx_t bDest,
    input  wire logic    bIsLoad,
    // Operand selects for E
    output bypassSel_t   aSSel,
    output bypassSel_t   aTSel,
    output bypassSel_t   bSSel,
    output bypassSel_t   bTSel,
    output logic         aSLoad,
    output logic         aTLoad,
    output logic         bSLoad,
    output logic         bTLoad,
    // Write-back controls from W
    output logic         bWasLoad,
    output logic         aWe,
    output logic         bWe,
    output regIdx_t      aWAddr,
    output regIdx_t      bWAddr,
    output logic         interlock
);

    // Destination pipeline, one entry per slot
    logic [numSlots-1:0] eValid, mValid, wValid;
    regIdx_t             eDest [numSlots];
    regIdx_t             mDest [numSlots];
    regIdx_t             wDest [numSlots];
    // Slot B load flags
    logic                eBLoad, mBLoad, wBLoad;

    regIdx_t             srcS [numSlots];
    regIdx_t             srcT [numSlots];
    bypassSel_t          sSelD [numSlots];
    bypassSel_t          tSelD [numSlots];
    bypassSel_t          sSelQ [numSlots];
    bypassSel_t          tSelQ [numSlots];
    logic [numSlots-1:0] sLoadD, tLoadD, sLoadQ, tLoadQ;
    logic [numSlots-1:0] sHazD, tHazD, sHazQ, tHazQ;

    assign srcS[0] = aSrcS;
    assign srcT[0] = aSrcT;
    assign srcS[1] = bSrcS;
    assign srcT[1] = bSrcT;

    // --------------------
    // Destination pipeline
    // --------------------
    always_ff @(posedge phi1 or negedge arstN) begin
        if (!arstN) begin
            eValid <= '0;
            mValid <= '0;
            wValid <= '0;
            eDest  <= '{default: '0};
            mDest  <= '{default: '0};
            wDest  <= '{default: '0};
            eBLoad <= 1'b0;
            mBLoad <= 1'b0;
            wBLoad <= 1'b0;
        end else begin
            eValid   <= {bValid, aValid};
            eDest[0] <= aDest;
            eDest[1] <= bDest;
            eBLoad   <= bValid && bIsLoad;
            mValid   <= eValid;
            mDest    <= eDest;
            mBLoad   <= eBLoad;
            wValid   <= mValid;
            wDest    <= mDest;
            wBLoad   <= mBLoad;
        end
    end

    // --------------------
    // Hazard compare
    // --------------------
    // E moves to M and M moves to W at the next edge
    // Younger wins: M over W, B over A
    function automatic bypassSel_t pickSel(input regIdx_t src);
        bypassSel_t sel;
        sel = '0;
        if (src == '0) begin
            sel[selNoneBit] = 1'b1;
        end else if (eValid[1] && (eDest[1] == src)) begin
            sel[selBMemBit] = 1'b1;
        end else if (eValid[0] && (eDest[0] == src)) begin
            sel[selAMemBit] = 1'b1;
        end else if (mValid[1] && (mDest[1] == src)) begin
            sel[selBWbBit] = 1'b1;
        end else if (mValid[0] && (mDest[0] == src)) begin
            sel[selAWbBit] = 1'b1;
        end else begin
            sel[selNoneBit] = 1'b1;
        end
        return sel;
    endfunction

    always_comb begin
        for (int i = 0; i < numSlots; i++) begin
            sSelD[i]  = pickSel(srcS[i]);
            tSelD[i]  = pickSel(srcT[i]);
            // Load reaching W supplies its load data instead
            sLoadD[i] = sSelD[i][selBWbBit] && mBLoad;
            tLoadD[i] = tSelD[i][selBWbBit] && mBLoad;
            // Load reaching M has no data yet
            sHazD[i]  = sSelD[i][selBMemBit] && eBLoad;
            tHazD[i]  = tSelD[i][selBMemBit] && eBLoad;
        end
    end

    always_ff @(posedge phi1 or negedge arstN) begin
        if (!arstN) begin
            sSelQ  <= '{default: selNone};
            tSelQ  <= '{default: selNone};
            sLoadQ <= '0;
            tLoadQ <= '0;
            sHazQ  <= '0;
            tHazQ  <= '0;
        end else begin
            sSelQ  <= sSelD;
            tSelQ  <= tSelD;
            sLoadQ <= sLoadD;
            tLoadQ <= tLoadD;
            sHazQ  <= sHazD;
            tHazQ  <= tHazD;
        end
    end

    assign aSSel  = sSelQ[0];
    assign aTSel  = tSelQ[0];
    assign bSSel  = sSelQ[1];
    assign bTSel  = tSelQ[1];
    assign aSLoad = sLoadQ[0];
    assign aTLoad = tLoadQ[0];
    assign bSLoad = sLoadQ[1];
    assign bTLoad = tLoadQ[1];

    // Valid E consumer of the slot B load now in M
    assign interlock = mBLoad && |((sHazQ | tHazQ) & eValid);

    // --------------------
    // Write-back
    // --------------------
    assign aWe      = wValid[0] && (wDest[0] != '0);
    assign bWe      = wValid[1] && (wDest[1] != '0);
    assign aWAddr   = wDest[0];
    assign bWAddr   = wDest[1];
    assign bWasLoad = wBLoad;

endmodule

`default_nettype wire

/* logic/bypassTop.sv */
// Bypass network top with register file, bypass specifier and two data lanes
`timescale 1ns/10ps
`default_nettype none

module bypassTop import bypassPkg::*; (
    input  wire logic    phi1,
    input  wire logic    arstN,
    // Slot A issue
    input  wire logic    aValid,
    input  wire regIdx_t aSrcS,
    input  wire regIdx_t aSrcT,
    input  wire regIdx_t aDest,
    // Slot B issue
    input  wire logic    bValid,
    input  wire regIdx_t bSrcS,
    input  wire regIdx_t bSrcT,
    input  wire regIdx_t bDest,
    input  wire logic    bIsLoad,
    // Results in E and load data in M
    input  wire word_t   aResult,
    input  wire word_t   bResult,
    input  wire word_t   memData,
    // Operands in E
    output word_t        aSBus,
    output word_t        aTBus,
    output word_t        bSBus,
    output word_t        bTBus,
    output logic         interlock
);

    // Per-slot lane signals, 0 is A and 1 is B
    word_t               readS  [numSlots];
    word_t               readT  [numSlots];
    word_t               result [numSlots];
    word_t               wbData [numSlots];
    word_t               sBus   [numSlots];
    word_t               tBus   [numSlots];
    bypassSel_t          sSel   [numSlots];
    bypassSel_t          tSel   [numSlots];
    logic                sLoad  [numSlots];
    logic                tLoad  [numSlots];
    logic [numSlots-1:0] wasLoad;
    logic                bWasLoad;
    logic                aWe, bWe;
    regIdx_t             aWAddr, bWAddr;

    assign result[0] = aResult;
    assign result[1] = bResult;
    // Only slot B issues loads
    assign wasLoad   = {bWasLoad, 1'b0};

    regFile i_regFile (
        .phi1   (phi1),
        .arstN  (arstN),
        .aSrcS  (aSrcS),
        .aSrcT  (aSrcT),
        .bSrcS  (bSrcS),
        .bSrcT  (bSrcT),
        .aWe    (aWe),
        .bWe    (bWe),
        .aWAddr (aWAddr),
        .bWAddr (bWAddr),
        .aWData (wbData[0]),
        .bWData (wbData[1]),
        .aReadS (readS[0]),
        .aReadT (readT[0]),
        .bReadS (readS[1]),
        .bReadT (readT[1])
    );

    bypassSpec i_bypassSpec (
        .phi1      (phi1),
        .arstN     (arstN),
        .aValid    (aValid),
        .bValid    (bValid),
        .aSrcS     (aSrcS),
        .aSrcT     (aSrcT),
        .aDest     (aDest),
        .bSrcS     (bSrcS),
        .bSrcT     (bSrcT),
        .bDest     (bDest),
        .bIsLoad   (bIsLoad),
        .aSSel     (sSel[0]),
        .aTSel     (tSel[0]),
        .bSSel     (sSel[1]),
        .bTSel     (tSel[1]),
        .aSLoad    (sLoad[0]),
        .aTLoad    (tLoad[0]),
        .bSLoad    (sLoad[1]),
        .bTLoad    (tLoad[1]),
        .bWasLoad  (bWasLoad),
        .aWe       (aWe),
        .bWe       (bWe),
        .aWAddr    (aWAddr),
        .bWAddr    (bWAddr),
        .interlock (interlock)
    );

    // --------------------
    // Data lanes
    // --------------------
    // Each lane gets its own slot's result on the B port
    // Lane A therefore sees swapped buses and mirrored selects
    for (genvar i = 0; i < numSlots; i++) begin : g_lane
        bypassData i_lane (
            .phi1    (phi1),
            .arstN   (arstN),
            .sSel    ((i == 0) ? mirrorSel(sSel[i]) : sSel[i]),
            .tSel    ((i == 0) ? mirrorSel(tSel[i]) : tSel[i]),
            .sLoad   (sLoad[i]),
            .tLoad   (tLoad[i]),
            .wasLoad (wasLoad[i]),
            .readS   (readS[i]),
            .readT   (readT[i]),
            .aResult (result[numSlots-1-i]),
            .bResult (result[i]),
            .memData (memData),
            .sBus    (sBus[i]),
            .tBus    (tBus[i]),
            .wbData  (wbData[i])
        );
    end

    assign aSBus = sBus[0];
    assign aTBus = tBus[0];
    assign bSBus = sBus[1];
    assign bTBus = tBus[1];

endmodule

`default_nettype wire

/* logic/regFile.sv */
// Register file with 32 words, two write ports and four write-through read ports
`timescale 1ns/10ps
`default_nettype none

module regFile import bypassPkg::*; (
    input  wire logic    phi1,
    input  wire logic    arstN,
    // Read addresses from R
    input  wire regIdx_t aSrcS,
    input  wire regIdx_t aSrcT,
    input  wire regIdx_t bSrcS,
    input  wire regIdx_t bSrcT,
    // Write ports from W
    input  wire logic    aWe,
    input  wire logic    bWe,
    input  wire regIdx_t aWAddr,
    input  wire regIdx_t bWAddr,
    input  wire word_t   aWData,
    input  wire word_t   bWData,
    // Read data
    output word_t        aReadS,
    output word_t        aReadT,
    output word_t        bReadS,
    output word_t        bReadT
);

    word_t regs [numRegs];

    // --------------------
    // Write
    // --------------------
    // B is the younger instruction so its write lands last
    always_ff @(posedge phi1 or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (aWe) begin
                regs[aWAddr] <= aWData;
            end
            if (bWe) begin
                regs[bWAddr] <= bWData;
            end
        end
    end

    // --------------------
    // Read
    // --------------------
    // Register 0 is hardwired zero
    // Same-cycle writes are forwarded, B ahead of A
    function automatic word_t readPort(input regIdx_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (bWe && (bWAddr == addr)) begin
            val = bWData;
        end else if (aWe && (aWAddr == addr)) begin
            val = aWData;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        aReadS = readPort(aSrcS);
        aReadT = readPort(aSrcT);
        bReadS = readPort(bSrcS);
        bReadT = readPort(bSrcT);
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module bypassTb -f filelist.f -o simv

out=$(./obj_dir/simv 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1

/* tb/bypassTb.sv */
// Testbench for the bypass network with clock, reset, vector reader, compare tasks and checks
`timescale 1ns/10ps
`default_nettype none

module bypassTb import bypassPkg::*; ();

    localparam int numVec       = 16;
    localparam int wordsPerVec  = 10;
    localparam int resetTimeout = 100;
    localparam int maxCycles    = 200;

    logic    phi1;
    logic    arstN;
    logic    aValid, bValid, bIsLoad;
    regIdx_t aSrcS, aSrcT, aDest;
    regIdx_t bSrcS, bSrcT, bDest;
    word_t   aResult, bResult, memData;
    word_t   aSBus, aTBus, bSBus, bTBus;
    logic    interlock;

    // Ten words per cycle as laid out in the vector file header
    word_t   vecMem [numVec*wordsPerVec];

    bypassTop i_bypassTop (
        .phi1      (phi1),
        .arstN     (arstN),
        .aValid    (aValid),
        .aSrcS     (aSrcS),
        .aSrcT     (aSrcT),
        .aDest     (aDest),
        .bValid    (bValid),
        .bSrcS     (bSrcS),
        .bSrcT     (bSrcT),
        .bDest     (bDest),
        .bIsLoad   (bIsLoad),
        .aResult   (aResult),
        .bResult   (bResult),
        .memData   (memData),
        .aSBus     (aSBus),
        .aTBus     (aTBus),
        .bSBus     (bSBus),
        .bTBus     (bTBus),
        .interlock (interlock)
    );

    bind bypassTop bypassTop_assertions i_assertions (
        .phi1      (phi1),
        .arstN     (arstN),
        .sSel      (sSel),
        .tSel      (tSel),
        .bValid    (bValid),
        .bIsLoad   (bIsLoad),
        .interlock (interlock),
        .aWe       (aWe),
        .bWe       (bWe),
        .aWAddr    (aWAddr),
        .bWAddr    (bWAddr)
    );

    // 20 ns clock
    always #10 phi1 = ~phi1;

    // --------------------
    // Compare tasks
    // --------------------
    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("ERR time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("ERR time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Issue fields packed as 0V SS TT DD with the slot B load flag on top
    task automatic applyVector(input int idx);
        word_t aCtrl;
        word_t bCtrl;
        aCtrl   = vecMem[idx*wordsPerVec];
        bCtrl   = vecMem[idx*wordsPerVec+1];
        aValid  = aCtrl[24];
        aSrcS   = aCtrl[20:16];
        aSrcT   = aCtrl[12:8];
        aDest   = aCtrl[4:0];
        bIsLoad = bCtrl[28];
        bValid  = bCtrl[24];
        bSrcS   = bCtrl[20:16];
        bSrcT   = bCtrl[12:8];
        bDest   = bCtrl[4:0];
        aResult = vecMem[idx*wordsPerVec+3];
        bResult = vecMem[idx*wordsPerVec+4];
        memData = vecMem[idx*wordsPerVec+5];
    endtask

    // Mask bits 7 to 4 enable the aS aT bS bT compares
    // Mask bit 0 holds the expected interlock
    task automatic checkVector(input int idx);
        word_t chk;
        int    base;
        base = idx*wordsPerVec;
        chk  = vecMem[base+2];
        if (chk[7]) checkWord("aSBus", vecMem[base+6], aSBus);
        if (chk[6]) checkWord("aTBus", vecMem[base+7], aTBus);
        if (chk[5]) checkWord("bSBus", vecMem[base+8], bSBus);
        if (chk[4]) checkWord("bTBus", vecMem[base+9], bTBus);
        checkFlag("interlock", chk[0], interlock);
    endtask

    task automatic waitForReset();
        int cnt;
        cnt = 0;
        while (arstN !== 1'b1) begin
            @(posedge phi1);
            cnt++;
            if (cnt > resetTimeout) begin
                $display("Reset was never released");
                $display("Simulation failed");
                $fatal(1);
            end
        end
    endtask

    // Reset held for 16 cycles
    initial begin
        phi1     = 1'b0;
        arstN    = 1'b0;
        aValid   = 1'b0;
        bValid   = 1'b0;
        bIsLoad  = 1'b0;
        aSrcS    = '0;
        aSrcT    = '0;
        aDest    = '0;
        bSrcS    = '0;
        bSrcT    = '0;
        bDest    = '0;
        aResult  = '0;
        bResult  = '0;
        memData  = '0;
        repeat (16) @(posedge phi1);
        #2 arstN = 1'b1;
    end

    // Watchdog
    initial begin
        for (int i = 0; i < maxCycles; i++) begin
            @(posedge phi1);
        end
        $display("Run did not finish within the cycle limit");
        $display("Simulation failed");
        $fatal(1);
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        $readmemh("tb/bypassVectors.mem", vecMem);
        waitForReset();
        #2;
        for (int v = 0; v < numVec; v++) begin
            applyVector(v);
            // Sample late in the cycle once the outputs settle
            #14;
            checkVector(v);
            @(posedge phi1);
            #2;
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/bypassTop_assertions.sv */
// Bound assertions on one-hot selects, interlock source and write-back addresses
`timescale 1ns/10ps
`default_nettype none

module bypassTop_assertions import bypassPkg::*; (
    input wire logic       phi1,
    input wire logic       arstN,
    input wire bypassSel_t sSel [numSlots],
    input wire bypassSel_t tSel [numSlots],
    input wire logic       bValid,
    input wire logic       bIsLoad,
    input wire logic       interlock,
    input wire logic       aWe,
    input wire logic       bWe,
    input wire regIdx_t    aWAddr,
    input wire regIdx_t    bWAddr
);

    // Every operand select names exactly one source
    for (genvar i = 0; i < numSlots; i++) begin : g_sel
        assert property (@(posedge phi1) disable iff (!arstN) $onehot(sSel[i]))
            else $error("S select is not one-hot in slot %0d", i);
        assert property (@(posedge phi1) disable iff (!arstN) $onehot(tSel[i]))
            else $error("T select is not one-hot in slot %0d", i);
    end

    // A slot B load issued two edges back is now in M
    assert property (@(posedge phi1) disable iff (!arstN)
        interlock |-> $past(bValid && bIsLoad, 2))
        else $error("Interlock without a slot B load in M");

    // Register 0 is never written
    assert property (@(posedge phi1) disable iff (!arstN) aWe |-> (aWAddr != '0))
        else $error("Slot A writes register 0");
    assert property (@(posedge phi1) disable iff (!arstN) bWe |-> (bWAddr != '0))
        else $error("Slot B writes register 0");

endmodule

`default_nettype wire

/* tb/bypassVectors.mem */
// Cols: aCtrl(0V SS TT DD) bCtrl(LV SS TT DD) chk(mask aS aT bS bT, interlock) aRes bRes
// memData expAS expAT expBS expBT; one line per cycle, operands belong to the E instruction
01050601 01070802 f0 00000000 00000000 00000000 00000000 00000000 00000000 00000000
01010203 01020104 f0 11111111 22222222 00000000 00000000 00000000 00000000 00000000
01010305 01040205 f0 33333333 44444444 00000000 11111111 22222222 22222222 11111111
01050006 01010505 f0 55555555 66666666 00000000 11111111 33333333 44444444 22222222
01050608 11000009 f0 77777777 88888888 00000000 66666666 00000000 11111111 66666666
0109080a 00000000 f0 99999999 0badbad0 00000000 88888888 77777777 00000000 00000000
0109000c 01090a0b 71 aaaaaaaa 00000000 cafef00d 00000000 99999999 00000000 00000000
0100000d 0100000d f0 cccccccc bbbbbbbb 00000000 cafef00d 00000000 cafef00d aaaaaaaa
01000000 00000000 f0 13131313 d0d0d0d0 00000000 00000000 00000000 00000000 00000000
00000000 00000000 f0 ffffffff 00000000 00000000 00000000 00000000 00000000 00000000
00010200 00030d00 f0 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00040500 00060800 f0 00000000 00000000 00000000 11111111 22222222 33333333 d0d0d0d0
00090a00 000b0c00 f0 00000000 00000000 00000000 44444444 88888888 77777777 99999999
000d0000 00000700 f0 00000000 00000000 00000000 cafef00d aaaaaaaa bbbbbbbb cccccccc
00000000 00000000 f0 00000000 00000000 00000000 d0d0d0d0 00000000 00000000 00000000
00000000 00000000 f0 00000000 00000000 00000000 00000000 00000000 00000000 00000000
